// ==== build.f ====
lcd_pkg.sv
lcd_bus_if.sv
lcd_init_seq.sv
lcd_rect_fill.sv
lcd_path_mux.sv
lcd_bus_writer.sv
lcd_top.sv
lcd_tb.sv

// ==== lcd_bus_if.sv ====
// lcd bus request channel: one panel write request and its status
`default_nettype none

interface lcd_bus_if
    import lcd_pkg::*;
();

    logic      we;   // one-cycle request, only while busy is low
    logic      rs;   // 0 command, 1 data
    lcd_word_u data;
    logic      busy;
    logic      done; // one-cycle pulse when the write completes

    modport requester (
        output we,
        output rs,
        output data,
        input  busy,
        input  done
    );

    modport writer (
        input  we,
        input  rs,
        input  data,
        output busy,
        output done
    );

endinterface

`default_nettype wire

// ==== lcd_bus_writer.sv ====
// lcd bus writer: panel reset hold, 8080 write strobe timing, chip select and backlight
`default_nettype none

module lcd_bus_writer
    import lcd_pkg::*;
(
    input  logic              pclk,
    input  logic              rst_n,
    lcd_bus_if.writer         bus,
    input  logic              init_done_i,
    output logic              lcd_rst_o,
    output logic              lcd_cs_o,
    output logic              lcd_rs_o,
    output logic              lcd_wr_o,
    output logic [DATA_W-1:0] lcd_data_o,
    output logic              lcd_bl_o
);

    logic [HOLD_CNT_W-1:0]   hold_cnt;
    logic [STROBE_CNT_W-1:0] phase;
    logic                    active;   // strobe in progress
    logic                    done_q;

    // panel held in reset for a fixed time after rst_n release
    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            lcd_rst_o <= 1'b0;
            hold_cnt  <= '0;
        end else if (!lcd_rst_o) begin
            if (hold_cnt == HOLD_CNT_W'(RST_HOLD_CYCLES - 1)) begin
                lcd_rst_o <= 1'b1;
            end else begin
                hold_cnt <= hold_cnt + 1'b1;
            end
        end
    end

    assign bus.busy = ~lcd_rst_o | active;
    assign bus.done = done_q;
    assign lcd_bl_o = init_done_i;  // backlight on once the panel is set up

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            active     <= 1'b0;
            phase      <= '0;
            done_q     <= 1'b0;
            lcd_cs_o   <= 1'b1;
            lcd_wr_o   <= 1'b1;
            lcd_rs_o   <= 1'b0;
            lcd_data_o <= '0;
        end else if (!active) begin
            if (bus.we && !bus.busy) begin
                active     <= 1'b1;
                phase      <= '0;
                lcd_cs_o   <= 1'b0;
                lcd_wr_o   <= 1'b0;
                lcd_rs_o   <= bus.rs;
                lcd_data_o <= bus.data.raw;
            end
        end else begin
            phase <= phase + 1'b1;
            if (phase == STROBE_CNT_W'(WR_LOW_CYCLES - 1)) begin
                lcd_wr_o <= 1'b1;  // panel samples data here
            end
            if (phase == STROBE_CNT_W'(STROBE_CYCLES - 2)) begin
                lcd_cs_o <= 1'b1;
                done_q   <= 1'b1;
            end
            if (phase == STROBE_CNT_W'(STROBE_CYCLES - 1)) begin
                active <= 1'b0;
                done_q <= 1'b0;
            end
        end
    end

    a_data_stable: assert property (
        @(posedge pclk) disable iff (!rst_n)
        !lcd_wr_o |=> lcd_wr_o || $stable(lcd_data_o)
    );

endmodule

`default_nettype wire

// ==== lcd_init_seq.sv ====
// lcd init sequencer: walks the init table after panel reset, flags completion
`default_nettype none

module lcd_init_seq
    import lcd_pkg::*;
(
    input  logic         pclk,
    input  logic         rst_n,
    lcd_bus_if.requester bus,
    output logic         init_done_o
);

    logic [INIT_IDX_W-1:0] idx;
    logic [DATA_W:0]       rom_entry;
    logic                  words_left;

    assign words_left = (idx < INIT_IDX_W'(INIT_LEN));

    always_comb begin
        rom_entry = '0;
        if (words_left) begin
            rom_entry = INIT_ROM[idx];
        end
    end

    // first word goes out as soon as the writer leaves panel reset
    assign bus.we       = words_left & ~bus.busy;
    assign bus.rs       = rom_entry[DATA_W];
    assign bus.data.raw = rom_entry[DATA_W-1:0];

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            idx         <= '0;
            init_done_o <= 1'b0;
        end else begin
            if (bus.we) begin
                idx <= idx + 1'b1;
            end
            // last word has been issued once idx is past the table
            if (bus.done && !words_left) begin
                init_done_o <= 1'b1;
            end
        end
    end

    // every request is taken up by the writer on the next cycle
    a_we_taken: assert property (
        @(posedge pclk) disable iff (!rst_n)
        bus.we |=> bus.busy
    );

endmodule

`default_nettype wire

// ==== lcd_path_mux.sv ====
// lcd path mux: gives the bus to init first, then to the fill path once idle
`default_nettype none

module lcd_path_mux
    import lcd_pkg::*;
(
    input  logic         pclk,
    input  logic         rst_n,
    input  logic         init_done_i,
    lcd_bus_if.writer    init_bus,
    lcd_bus_if.writer    fill_bus,
    lcd_bus_if.requester out_bus
);

    logic grant_fill;

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            grant_fill <= 1'b0;
        end else if (!grant_fill && init_done_i && !out_bus.busy) begin
            grant_fill <= 1'b1;  // one-way switch
        end
    end

    assign out_bus.we   = grant_fill ? fill_bus.we   : init_bus.we;
    assign out_bus.rs   = grant_fill ? fill_bus.rs   : init_bus.rs;
    assign out_bus.data = grant_fill ? fill_bus.data : init_bus.data;

    // ungranted side stalls on busy and never sees done
    assign init_bus.busy = grant_fill | out_bus.busy;
    assign init_bus.done = ~grant_fill & out_bus.done;
    assign fill_bus.busy = ~grant_fill | out_bus.busy;
    assign fill_bus.done = grant_fill & out_bus.done;

    // no request may be starting or running when the grant moves
    a_grant_idle: assert property (
        @(posedge pclk) disable iff (!rst_n)
        !$stable(grant_fill) |-> !$past(out_bus.busy) && !$past(out_bus.we)
    );

endmodule

`default_nettype wire

// ==== lcd_pkg.sv ====
// lcd panel package: timing, widths, command codes, init table and bus word union
`default_nettype none

package lcd_pkg;

    localparam int DATA_W  = 16;
    localparam int COORD_W = 9; // 320x240 panel

    // write strobe shape, in pclk cycles
    localparam int WR_LOW_CYCLES  = 2;
    localparam int WR_HIGH_CYCLES = 2;
    localparam int STROBE_CYCLES  = WR_LOW_CYCLES + WR_HIGH_CYCLES;
    localparam int STROBE_CNT_W   = $clog2(STROBE_CYCLES);

    localparam int RST_HOLD_CYCLES = 16; // panel reset low after rst_n release
    localparam int HOLD_CNT_W      = $clog2(RST_HOLD_CYCLES);

    localparam logic [DATA_W-1:0] CMD_COL_ADDR  = 16'h002A;
    localparam logic [DATA_W-1:0] CMD_PAGE_ADDR = 16'h002B;
    localparam logic [DATA_W-1:0] CMD_MEM_WRITE = 16'h002C;

    // fill header: col cmd + 4 bytes, page cmd + 4 bytes, mem write cmd
    localparam int FILL_HDR_WORDS = 11;
    localparam int FILL_PHASE_W   = $clog2(FILL_HDR_WORDS + 1);

    // init table entry is {rs, word}
    localparam int INIT_LEN   = 6;
    localparam int INIT_IDX_W = $clog2(INIT_LEN + 1);
    localparam logic [DATA_W:0] INIT_ROM [INIT_LEN] = '{
        {1'b0, 16'h0011},  // sleep out
        {1'b0, 16'h003A},  // pixel format
        {1'b1, 16'h0055},  // 16 bpp
        {1'b0, 16'h0036},  // memory access control
        {1'b1, 16'h0000},
        {1'b0, 16'h0029}   // display on
    };

    // one bus word, seen raw or as an rgb565 pixel
    typedef union packed {
        logic [DATA_W-1:0] raw;
        struct packed {
            logic [4:0] r;
            logic [5:0] g;
            logic [4:0] b;
        } pixel;
    } lcd_word_u;

endpackage

`default_nettype wire

// ==== lcd_rect_fill.sv ====
// lcd rectangle fill: turns a rectangle request into address commands and pixel words
`default_nettype none

module lcd_rect_fill
    import lcd_pkg::*;
(
    input  logic               pclk,
    input  logic               rst_n,
    input  logic               draw_start_i,
    input  logic [COORD_W-1:0] x0_i,
    input  logic [COORD_W-1:0] y0_i,
    input  logic [COORD_W-1:0] x1_i,
    input  logic [COORD_W-1:0] y1_i,
    input  lcd_word_u          color_i,
    lcd_bus_if.requester       bus,
    output logic               draw_busy_o
);

    logic [COORD_W-1:0]      x0_q, y0_q, x1_q, y1_q;
    logic [COORD_W-1:0]      px, py;  // current pixel position
    lcd_word_u               color_q;
    lcd_word_u               word_d;
    logic [FILL_PHASE_W-1:0] phase;
    logic                    all_sent;
    logic                    accept;
    logic                    pixel_phase;
    logic                    last_pix;

    function automatic logic [DATA_W-1:0] hi_byte(input logic [COORD_W-1:0] c);
        logic [DATA_W-1:0] w;
        w = DATA_W'(c);
        return {8'h00, w[15:8]};
    endfunction

    function automatic logic [DATA_W-1:0] lo_byte(input logic [COORD_W-1:0] c);
        logic [DATA_W-1:0] w;
        w = DATA_W'(c);
        return {8'h00, w[7:0]};
    endfunction

    assign accept      = draw_start_i & ~draw_busy_o;  // ignored while drawing
    assign pixel_phase = (phase == FILL_PHASE_W'(FILL_HDR_WORDS));
    assign last_pix    = pixel_phase & (px == x1_q) & (py == y1_q);

    always_comb begin
        word_d = '0;
        bus.rs = 1'b1;
        case (phase)
            4'd0: begin
                word_d.raw = CMD_COL_ADDR;
                bus.rs     = 1'b0;
            end
            4'd1:  word_d.raw = hi_byte(x0_q);
            4'd2:  word_d.raw = lo_byte(x0_q);
            4'd3:  word_d.raw = hi_byte(x1_q);
            4'd4:  word_d.raw = lo_byte(x1_q);
            4'd5: begin
                word_d.raw = CMD_PAGE_ADDR;
                bus.rs     = 1'b0;
            end
            4'd6:  word_d.raw = hi_byte(y0_q);
            4'd7:  word_d.raw = lo_byte(y0_q);
            4'd8:  word_d.raw = hi_byte(y1_q);
            4'd9:  word_d.raw = lo_byte(y1_q);
            4'd10: begin
                word_d.raw = CMD_MEM_WRITE;
                bus.rs     = 1'b0;
            end
            default: word_d.pixel = color_q.pixel;
        endcase
    end

    assign bus.data = word_d;
    assign bus.we   = draw_busy_o & ~all_sent & ~bus.busy;

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            draw_busy_o <= 1'b0;
            all_sent    <= 1'b0;
            phase       <= '0;
        end else if (accept) begin
            draw_busy_o <= 1'b1;
            all_sent    <= 1'b0;
            phase       <= '0;
        end else begin
            if (bus.we && !pixel_phase) begin
                phase <= phase + 1'b1;
            end
            if (bus.we && last_pix) begin
                all_sent <= 1'b1;
            end
            if (bus.done && all_sent) begin
                draw_busy_o <= 1'b0;  // low the cycle after the last done
            end
        end
    end

    // rectangle and scan position, row by row
    always_ff @(posedge pclk) begin
        if (accept) begin
            x0_q    <= x0_i;
            y0_q    <= y0_i;
            x1_q    <= x1_i;
            y1_q    <= y1_i;
            color_q <= color_i;
            px      <= x0_i;
            py      <= y0_i;
        end else if (bus.we && pixel_phase) begin
            if (px == x1_q) begin
                px <= x0_q;
                py <= py + 1'b1;
            end else begin
                px <= px + 1'b1;
            end
        end
    end

    a_rect_order: assert property (
        @(posedge pclk) disable iff (!rst_n)
        accept |-> (x1_i >= x0_i) && (y1_i >= y0_i)
    );

endmodule

`default_nettype wire

// ==== lcd_tb.sv ====
// lcd controller testbench: table-driven draws checked word by word against a bus monitor
`default_nettype none

module lcd_tb
    import lcd_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_HALF   = 20;
    localparam int DRIVE_DLY  = 2;
    localparam int RST_CYCLES = 10;
    localparam int NUM_REQ    = 4;

    typedef struct packed {
        logic [COORD_W-1:0] x0;
        logic [COORD_W-1:0] y0;
        logic [COORD_W-1:0] x1;
        logic [COORD_W-1:0] y1;
        logic [4:0]         r;
        logic [5:0]         g;
        logic [4:0]         b;
        logic               early;  // issued while init is still running
    } draw_req_t;

    logic               pclk;
    logic               rst_n;
    logic               draw_start_i;
    logic [COORD_W-1:0] x0_i, y0_i, x1_i, y1_i;
    logic [4:0]         color_r_i;
    logic [5:0]         color_g_i;
    logic [4:0]         color_b_i;
    logic               draw_busy_o;
    logic               init_done_o;
    logic               lcd_rst_o, lcd_cs_o, lcd_rs_o, lcd_wr_o;
    logic [DATA_W-1:0]  lcd_data_o;
    logic               lcd_bl_o;

    draw_req_t   req_tab [NUM_REQ];
    logic        exp_rs [$];
    lcd_word_u   exp_word [$];
    logic        obs_rs [$];
    lcd_word_u   obs_word [$];
    logic [15:0] lfsr_state;
    logic        wr_prev;
    logic        cs_was_high;  // cs seen high since the last wr edge
    lcd_word_u   cap;
    int          cycle_cnt = 0;
    int          timeout_limit;

    lcd_top i_lcd_top (
        .pclk         (pclk),
        .rst_n        (rst_n),
        .draw_start_i (draw_start_i),
        .x0_i         (x0_i),
        .y0_i         (y0_i),
        .x1_i         (x1_i),
        .y1_i         (y1_i),
        .color_r_i    (color_r_i),
        .color_g_i    (color_g_i),
        .color_b_i    (color_b_i),
        .draw_busy_o  (draw_busy_o),
        .init_done_o  (init_done_o),
        .lcd_rst_o    (lcd_rst_o),
        .lcd_cs_o     (lcd_cs_o),
        .lcd_rs_o     (lcd_rs_o),
        .lcd_wr_o     (lcd_wr_o),
        .lcd_data_o   (lcd_data_o),
        .lcd_bl_o     (lcd_bl_o)
    );

    initial pclk = 1'b0;
    always #CLK_HALF pclk = ~pclk;

    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_error(input string why);
        $display("ERROR: %s", why);
        abort_run();
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_word(input string name, input lcd_word_u got, input lcd_word_u exp);
        if (got.raw !== exp.raw) begin
            $display("[FAIL] %s got 0x%04h expected 0x%04h", name, got.raw, exp.raw);
            abort_run();
        end
    endtask

    // galois lfsr, taps 16,14,13,11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    task automatic take_bits(input int n, output int v);
        int k;
        v = 0;
        for (k = 0; k < n; k++) begin
            v = (v << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic int rect_area(input draw_req_t q);
        return (int'(q.x1) - int'(q.x0) + 1) * (int'(q.y1) - int'(q.y0) + 1);
    endfunction

    task automatic build_table();
        int i;
        int v;
        int w;
        req_tab[0] = '{x0: 9'd5, y0: 9'd7, x1: 9'd5, y1: 9'd7,
                       r: 5'h1F, g: 6'h00, b: 5'h00, early: 1'b1};
        // 3x2 block across the 256 column boundary
        req_tab[1] = '{x0: 9'd254, y0: 9'd200, x1: 9'd256, y1: 9'd201,
                       r: 5'h0A, g: 6'h2C, b: 5'h13, early: 1'b0};
        for (i = 2; i < NUM_REQ; i++) begin
            take_bits(9, v);
            req_tab[i].x0 = COORD_W'(v % 312);
            take_bits(3, w);
            req_tab[i].x1 = req_tab[i].x0 + COORD_W'(w);  // at most 8 wide
            take_bits(8, v);
            req_tab[i].y0 = COORD_W'(v % 232);
            take_bits(3, w);
            req_tab[i].y1 = req_tab[i].y0 + COORD_W'(w);
            take_bits(5, v);
            req_tab[i].r = 5'(v);
            take_bits(6, v);
            req_tab[i].g = 6'(v);
            take_bits(5, v);
            req_tab[i].b = 5'(v);
            req_tab[i].early = 1'b0;
        end
    endtask

    task automatic push_word(input logic rs, input logic [DATA_W-1:0] w);
        lcd_word_u e;
        e.raw = w;
        exp_rs.push_back(rs);
        exp_word.push_back(e);
    endtask

    task automatic push_init_words();
        int i;
        for (i = 0; i < INIT_LEN; i++) begin
            push_word(INIT_ROM[i][DATA_W], INIT_ROM[i][DATA_W-1:0]);
        end
    endtask

    task automatic push_rect_words(input draw_req_t q);
        int i;
        push_word(1'b0, CMD_COL_ADDR);
        push_word(1'b1, DATA_W'(q.x0 >> 8));
        push_word(1'b1, DATA_W'(q.x0[7:0]));
        push_word(1'b1, DATA_W'(q.x1 >> 8));
        push_word(1'b1, DATA_W'(q.x1[7:0]));
        push_word(1'b0, CMD_PAGE_ADDR);
        push_word(1'b1, DATA_W'(q.y0 >> 8));
        push_word(1'b1, DATA_W'(q.y0[7:0]));
        push_word(1'b1, DATA_W'(q.y1 >> 8));
        push_word(1'b1, DATA_W'(q.y1[7:0]));
        push_word(1'b0, CMD_MEM_WRITE);
        for (i = 0; i < rect_area(q); i++) begin
            push_word(1'b1, {q.r, q.g, q.b});  // rgb565
        end
    endtask

    task automatic issue_draw(input draw_req_t q);
        @(posedge pclk);
        #DRIVE_DLY;
        x0_i = q.x0;
        y0_i = q.y0;
        x1_i = q.x1;
        y1_i = q.y1;
        color_r_i = q.r;
        color_g_i = q.g;
        color_b_i = q.b;
        draw_start_i = 1'b1;
        @(posedge pclk);
        #DRIVE_DLY;
        draw_start_i = 1'b0;
        @(negedge pclk);
        check_bit("draw_busy_o", draw_busy_o, 1'b1);
    endtask

    // a large request while drawing, must add nothing
    task automatic poke_while_busy();
        @(posedge pclk);
        #DRIVE_DLY;
        x0_i = '0;
        y0_i = '0;
        x1_i = 9'd99;
        y1_i = 9'd99;
        color_r_i = ~color_r_i;
        draw_start_i = 1'b1;
        @(posedge pclk);
        #DRIVE_DLY;
        draw_start_i = 1'b0;
    endtask

    task automatic compare_expected();
        logic      e_rs;
        logic      o_rs;
        lcd_word_u e_w;
        lcd_word_u o_w;
        int        n;
        n = 0;
        while (exp_word.size() > 0) begin
            if (obs_word.size() == 0) begin
                report_error($sformatf("expected word %0d was never written to the panel", n));
            end
            e_rs = exp_rs.pop_front();
            e_w  = exp_word.pop_front();
            o_rs = obs_rs.pop_front();
            o_w  = obs_word.pop_front();
            check_bit($sformatf("lcd_rs_o word %0d", n), o_rs, e_rs);
            check_word($sformatf("lcd_data_o word %0d", n), o_w, e_w);
            n++;
        end
        if (obs_word.size() != 0) begin
            report_error($sformatf("%0d extra words were written", obs_word.size()));
        end
    endtask

    // bus monitor, sampled on the falling clock edge
    always @(negedge pclk) begin
        if (!rst_n) begin
            wr_prev     = 1'b1;
            cs_was_high = 1'b1;
        end else begin
            if (lcd_wr_o && !wr_prev) begin
                check_bit("lcd_cs_o at wr rise", lcd_cs_o, 1'b0);
                check_bit("lcd_cs_o high between writes", cs_was_high, 1'b1);
                cap.raw = lcd_data_o;
                obs_rs.push_back(lcd_rs_o);
                obs_word.push_back(cap);
                cs_was_high = 1'b0;
            end else if (lcd_cs_o) begin
                cs_was_high = 1'b1;
            end
            wr_prev = lcd_wr_o;
        end
    end

    always @(posedge pclk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > timeout_limit) begin
            report_error($sformatf("timeout after %0d cycles", cycle_cnt));
        end
    end

    initial begin
        int        i;
        int        total;
        lcd_word_u bus_word;
        rst_n = 1'b0;
        draw_start_i = 1'b0;
        x0_i = '0;
        y0_i = '0;
        x1_i = '0;
        y1_i = '0;
        color_r_i = '0;
        color_g_i = '0;
        color_b_i = '0;
        lfsr_state = 16'd59765;
        build_table();
        push_init_words();
        total = INIT_LEN;
        for (i = 0; i < NUM_REQ; i++) begin
            total += 11 + rect_area(req_tab[i]);
        end
        timeout_limit = total * (WR_LOW_CYCLES + WR_HIGH_CYCLES + 2) + RST_HOLD_CYCLES + 200;

        repeat (RST_CYCLES - 1) @(posedge pclk);
        @(negedge pclk);
        bus_word.raw = lcd_data_o;
        check_bit("lcd_rs_o", lcd_rs_o, 1'b0);
        check_word("lcd_data_o", bus_word, '0);
        @(posedge pclk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        @(negedge pclk);
        check_bit("lcd_rst_o", lcd_rst_o, 1'b0);  // still in panel reset hold
        check_bit("lcd_cs_o", lcd_cs_o, 1'b1);
        check_bit("lcd_wr_o", lcd_wr_o, 1'b1);
        check_bit("init_done_o", init_done_o, 1'b0);
        check_bit("draw_busy_o", draw_busy_o, 1'b0);
        check_bit("lcd_bl_o", lcd_bl_o, 1'b0);
        while (!lcd_rst_o) @(negedge pclk);
        if (obs_word.size() != 0) begin
            report_error("the panel was written before its reset was released");
        end

        for (i = 0; i < NUM_REQ; i++) begin
            if (req_tab[i].early) begin
                check_bit("init_done_o", init_done_o, 1'b0);
            end else begin
                while (!init_done_o) @(negedge pclk);
                compare_expected();
            end
            push_rect_words(req_tab[i]);
            issue_draw(req_tab[i]);
            poke_while_busy();
            while (draw_busy_o) @(negedge pclk);
            compare_expected();  // init words come first if still pending
            check_bit("init_done_o", init_done_o, 1'b1);
            check_bit("lcd_bl_o", lcd_bl_o, 1'b1);
        end

        repeat (20) @(negedge pclk);
        check_bit("lcd_cs_o", lcd_cs_o, 1'b1);
        if (obs_word.size() != 0) begin
            report_error("words were written after the last draw finished");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== lcd_top.sv ====
// lcd controller top: init sequencer and rectangle fill sharing one 8080 write bus
`default_nettype none

module lcd_top
    import lcd_pkg::*;
(
    input  logic               pclk,
    input  logic               rst_n,
    input  logic               draw_start_i,
    input  logic [COORD_W-1:0] x0_i,
    input  logic [COORD_W-1:0] y0_i,
    input  logic [COORD_W-1:0] x1_i,
    input  logic [COORD_W-1:0] y1_i,
    input  logic [4:0]         color_r_i,
    input  logic [5:0]         color_g_i,
    input  logic [4:0]         color_b_i,
    output logic               draw_busy_o,
    output logic               init_done_o,
    output logic               lcd_rst_o,
    output logic               lcd_cs_o,
    output logic               lcd_rs_o,
    output logic               lcd_wr_o,
    output logic [DATA_W-1:0]  lcd_data_o,
    output logic               lcd_bl_o
);

    lcd_word_u color;

    // rgb565 packing
    assign color.pixel.r = color_r_i;
    assign color.pixel.g = color_g_i;
    assign color.pixel.b = color_b_i;

    lcd_bus_if init_if ();
    lcd_bus_if fill_if ();
    lcd_bus_if wr_if ();

    lcd_init_seq i_lcd_init_seq (
        .pclk        (pclk),
        .rst_n       (rst_n),
        .bus         (init_if),
        .init_done_o (init_done_o)
    );

    lcd_rect_fill i_lcd_rect_fill (
        .pclk         (pclk),
        .rst_n        (rst_n),
        .draw_start_i (draw_start_i),
        .x0_i         (x0_i),
        .y0_i         (y0_i),
        .x1_i         (x1_i),
        .y1_i         (y1_i),
        .color_i      (color),
        .bus          (fill_if),
        .draw_busy_o  (draw_busy_o)
    );

    lcd_path_mux i_lcd_path_mux (
        .pclk        (pclk),
        .rst_n       (rst_n),
        .init_done_i (init_done_o),
        .init_bus    (init_if),
        .fill_bus    (fill_if),
        .out_bus     (wr_if)
    );

    lcd_bus_writer i_lcd_bus_writer (
        .pclk        (pclk),
        .rst_n       (rst_n),
        .bus         (wr_if),
        .init_done_i (init_done_o),
        .lcd_rst_o   (lcd_rst_o),
        .lcd_cs_o    (lcd_cs_o),
        .lcd_rs_o    (lcd_rs_o),
        .lcd_wr_o    (lcd_wr_o),
        .lcd_data_o  (lcd_data_o),
        .lcd_bl_o    (lcd_bl_o)
    );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# build the lcd controller testbench with verilator and run it
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module lcd_tb -f build.f -o Vlcd_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vlcd_tb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi
exit 0
